/* mipsLitePkg.sv */
package mipsLitePkg;

    localparam logic [31:0] defaultResetPc = 32'h0000_3000;

    //////////////////////////////////////////////////
    // Instruction fields
    //////////////////////////////////////////////////

    typedef enum logic [5:0] {
        opSpecial = 6'b000000,
        opJal     = 6'b000011,
        opBeq     = 6'b000100,
        opBne     = 6'b000101,
        opAddi    = 6'b001000,
        opAddiu   = 6'b001001,
        opAndi    = 6'b001100,
        opOri     = 6'b001101,
        opLui     = 6'b001111
    } opcodeT;

    typedef enum logic [5:0] {
        fnJr   = 6'b001000,
        fnAdd  = 6'b100000,
        fnAddu = 6'b100001,
        fnSub  = 6'b100010,
        fnSubu = 6'b100011,
        fnAnd  = 6'b100100,
        fnOr   = 6'b100101,
        fnSlt  = 6'b101010,
        fnSltu = 6'b101011
    } funcT;

    //////////////////////////////////////////////////
    // Control selections
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluSltu, aluPassB
    } aluOpT;

    typedef enum logic [1:0] {npcPc4, npcBranch, npcJumpLink, npcJumpReg} npcOpT;
    typedef enum logic {cmpBeq, cmpBne} cmpOpT;
    typedef enum logic [1:0] {extZero, extSign, extUpper} extOpT;
    typedef enum logic [1:0] {wrRt, wrRd, wrR31} wrRegSelT;
    typedef enum logic {wdAluResult, wdPcPlus8} wrDataSelT;
    typedef enum logic [1:0] {excNone, excReservedInstr, excOverflow} excCodeT;

    // Decoder output toward the execution unit
    typedef struct packed {
        aluOpT     aluOp;
        logic      aluBImm;
        extOpT     extOp;
        npcOpT     npcOp;
        cmpOpT     cmpOp;
        logic      regWrite;
        wrRegSelT  wrRegSel;
        wrDataSelT wrDataSel;
        logic      checkOverflow;
        logic      reserved;
    } ctrlBundleT;

    // One retired instruction
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic        regWrite;
        logic [4:0]  wrReg;
        logic [31:0] wrData;
        excCodeT     exc;
    } retireRecordT;

endpackage

/* instrReceiver.sv */
`timescale 1ns/1ns

module instrReceiver (
    input  logic        clk,
    input  logic        reset,
    input  logic        inReq,
    input  logic [31:0] instr,
    output logic        inAck,
    output logic        instrValid,
    output logic [31:0] instrWord,
    input  logic        instrTaken
);

    logic capture;

    // New request only while idle on the link and the buffer is empty
    assign capture = inReq && !inAck && !instrValid;

    // inAck doubles as the handshake phase
    // so a request still held high is never captured twice
    always_ff @(posedge clk) begin
        if (reset) begin
            inAck      <= 1'b0;
            instrValid <= 1'b0;
        end else begin
            if (capture) begin
                inAck      <= 1'b1;
                instrValid <= 1'b1;
            end else begin
                if (!inReq) begin
                    inAck <= 1'b0;
                end
                if (instrTaken) begin
                    instrValid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            instrWord <= instr;
        end
    end

endmodule

/* controlUnit.sv */
`timescale 1ns/1ns

module controlUnit import mipsLitePkg::*; (
    input  logic [31:0] instrWord,
    output ctrlBundleT  ctrl
);

    opcodeT opcode;
    funcT   func;
    logic   special;
    logic   isAdd, isAddu, isSub, isSubu, isAnd, isOr, isSlt, isSltu, isJr;
    logic   isAddi, isAddiu, isAndi, isOri, isLui, isBeq, isBne, isJal;
    logic   isNop, calcR, calcI, known;

    assign opcode  = opcodeT'(instrWord[31:26]);
    assign func    = funcT'(instrWord[5:0]);
    assign special = (opcode == opSpecial);

    //////////////////////////////////////////////////
    // Identify instruction
    //////////////////////////////////////////////////

    assign isAdd  = special && (func == fnAdd);
    assign isAddu = special && (func == fnAddu);
    assign isSub  = special && (func == fnSub);
    assign isSubu = special && (func == fnSubu);
    assign isAnd  = special && (func == fnAnd);
    assign isOr   = special && (func == fnOr);
    assign isSlt  = special && (func == fnSlt);
    assign isSltu = special && (func == fnSltu);
    assign isJr   = special && (func == fnJr);

    assign isAddi  = (opcode == opAddi);
    assign isAddiu = (opcode == opAddiu);
    assign isAndi  = (opcode == opAndi);
    assign isOri   = (opcode == opOri);
    assign isLui   = (opcode == opLui);
    assign isBeq   = (opcode == opBeq);
    assign isBne   = (opcode == opBne);
    assign isJal   = (opcode == opJal);

    // sll $0, $0, 0
    assign isNop = (instrWord == 32'd0);

    assign calcR = isAdd || isAddu || isSub || isSubu || isAnd || isOr || isSlt || isSltu;
    assign calcI = isAddi || isAddiu || isAndi || isOri;
    assign known = calcR || calcI || isLui || isBeq || isBne || isJal || isJr || isNop;

    //////////////////////////////////////////////////
    // Control signals
    //////////////////////////////////////////////////

    always_comb begin
        ctrl.aluOp = (isSub || isSubu) ? aluSub :
                     (isAnd || isAndi) ? aluAnd :
                     (isOr || isOri || isNop) ? aluOr :
                     isSlt ? aluSlt :
                     isSltu ? aluSltu :
                     isLui ? aluPassB :
                     aluAdd;

        ctrl.aluBImm = calcI || isLui;

        ctrl.extOp = (isAddi || isAddiu || isBeq || isBne) ? extSign :
                     isLui ? extUpper :
                     extZero;

        ctrl.npcOp = (isBeq || isBne) ? npcBranch :
                     isJal ? npcJumpLink :
                     isJr ? npcJumpReg :
                     npcPc4;

        ctrl.cmpOp = isBne ? cmpBne : cmpBeq;

        // Unknown encodings never write
        ctrl.regWrite = calcR || calcI || isLui || isJal || isNop;

        ctrl.wrRegSel = (calcI || isLui) ? wrRt :
                        isJal ? wrR31 :
                        wrRd;

        ctrl.wrDataSel = isJal ? wdPcPlus8 : wdAluResult;

        // Trapping arithmetic
        ctrl.checkOverflow = isAdd || isAddi || isSub;

        ctrl.reserved = !known;
    end

endmodule

/* regFile.sv */
`timescale 1ns/1ns

module regFile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rdAddrA,
    input  logic [4:0]  rdAddrB,
    output logic [31:0] rdDataA,
    output logic [31:0] rdDataB,
    input  logic        wrEn,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData
);

    logic [31:0] regs [32];

    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

    // Register 0 is never written and so stays zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wrEn && (wrAddr != 5'd0)) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

/* execUnit.sv */
`timescale 1ns/1ns

module execUnit import mipsLitePkg::*; #(
    parameter logic [31:0] resetPc = defaultResetPc
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         instrValid,
    input  logic [31:0]  instrWord,
    output logic         instrTaken,
    input  ctrlBundleT   ctrl,
    input  logic [31:0]  rdDataA,
    input  logic [31:0]  rdDataB,
    output logic         wrEn,
    output logic [4:0]   wrAddr,
    output logic [31:0]  wrData,
    output retireRecordT retire,
    output logic         retireValid,
    input  logic         senderFree
);

    logic [31:0]  pc, pcPlus4, pcPlus8, immExt, aluB, sum, diff, aluResult;
    logic [31:0]  branchTarget, jumpTarget, nextPc, writeValue;
    logic [4:0]   destReg;
    logic         take, overflow, branchTaken, squash;
    retireRecordT retireNext;

    assign take       = instrValid && senderFree;
    assign instrTaken = take;

    assign pcPlus4 = pc + 32'd4;
    assign pcPlus8 = pc + 32'd8;

    always_comb begin
        case (ctrl.extOp)
            extSign:  immExt = {{16{instrWord[15]}}, instrWord[15:0]};
            extUpper: immExt = {instrWord[15:0], 16'd0};
            default:  immExt = {16'd0, instrWord[15:0]};
        endcase
    end

    //////////////////////////////////////////////////
    // ALU and overflow
    //////////////////////////////////////////////////

    assign aluB = ctrl.aluBImm ? immExt : rdDataB;
    assign sum  = rdDataA + aluB;
    assign diff = rdDataA - aluB;

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:   aluResult = sum;
            aluSub:   aluResult = diff;
            aluAnd:   aluResult = rdDataA & aluB;
            aluOr:    aluResult = rdDataA | aluB;
            aluSlt:   aluResult = {31'd0, $signed(rdDataA) < $signed(aluB)};
            aluSltu:  aluResult = {31'd0, rdDataA < aluB};
            aluPassB: aluResult = aluB;
            default:  aluResult = 32'd0;
        endcase
    end

    // Signs of the operands agree with each other but not with the result
    assign overflow = ctrl.checkOverflow &&
        ((ctrl.aluOp == aluSub) ?
            ((rdDataA[31] != aluB[31]) && (diff[31] != rdDataA[31])) :
            ((rdDataA[31] == aluB[31]) && (sum[31] != rdDataA[31])));

    assign squash = ctrl.reserved || overflow;

    //////////////////////////////////////////////////
    // Next pc
    //////////////////////////////////////////////////

    assign branchTaken  = (ctrl.cmpOp == cmpBeq) ? (rdDataA == rdDataB) : (rdDataA != rdDataB);
    assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};
    assign jumpTarget   = {pc[31:28], instrWord[25:0], 2'b00};

    always_comb begin
        case (ctrl.npcOp)
            npcBranch:   nextPc = branchTaken ? branchTarget : pcPlus4;
            npcJumpLink: nextPc = jumpTarget;
            npcJumpReg:  nextPc = rdDataA;
            default:     nextPc = pcPlus4;
        endcase
        if (squash) begin
            nextPc = pcPlus4;
        end
    end

    // Write-back
    always_comb begin
        case (ctrl.wrRegSel)
            wrRt:    destReg = instrWord[20:16];
            wrR31:   destReg = 5'd31;
            default: destReg = instrWord[15:11];
        endcase
    end

    assign writeValue = (ctrl.wrDataSel == wdPcPlus8) ? pcPlus8 : aluResult;

    assign wrEn   = take && ctrl.regWrite && !squash;
    assign wrAddr = destReg;
    assign wrData = writeValue;

    always_comb begin
        retireNext.pc       = pc;
        retireNext.nextPc   = nextPc;
        retireNext.regWrite = ctrl.regWrite && !squash;
        retireNext.wrReg    = destReg;
        retireNext.wrData   = writeValue;
        retireNext.exc      = ctrl.reserved ? excReservedInstr :
                              overflow ? excOverflow : excNone;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= resetPc;
            retireValid <= 1'b0;
        end else begin
            retireValid <= take;
            if (take) begin
                pc <= nextPc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            retire <= retireNext;
        end
    end

endmodule

/* resultSender.sv */
`timescale 1ns/1ns

module resultSender import mipsLitePkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  retireRecordT retire,
    input  logic         retireValid,
    output logic         senderFree,
    output logic         outReq,
    output retireRecordT record,
    input  logic         outAck
);

    typedef enum logic [1:0] {phIdle, phRequest, phRelease} phaseT;

    phaseT phase;

    assign outReq = (phase == phRequest);

    // Busy as soon as a record is on its way in
    assign senderFree = (phase == phIdle) && !retireValid;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= phIdle;
        end else begin
            case (phase)
                phIdle:    if (retireValid) phase <= phRequest;
                phRequest: if (outAck) phase <= phRelease;
                phRelease: if (!outAck) phase <= phIdle;
                default:   phase <= phIdle;
            endcase
        end
    end

    // Held steady for the whole request phase
    always_ff @(posedge clk) begin
        if ((phase == phIdle) && retireValid) begin
            record <= retire;
        end
    end

endmodule

/* mipsLiteTop.sv */
`timescale 1ns/1ns

module mipsLiteTop import mipsLitePkg::*; #(
    parameter logic [31:0] resetPc = defaultResetPc
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         inReq,
    input  logic [31:0]  instr,
    output logic         inAck,
    output logic         outReq,
    output retireRecordT record,
    input  logic         outAck
);

    logic         instrValid, instrTaken, wrEn, retireValid, senderFree;
    logic [31:0]  instrWord, rdDataA, rdDataB, wrData;
    logic [4:0]   wrAddr;
    ctrlBundleT   ctrl;
    retireRecordT retire;

    instrReceiver receiver0 (
        .clk(clk), .reset(reset), .inReq(inReq), .instr(instr), .inAck(inAck),
        .instrValid(instrValid), .instrWord(instrWord), .instrTaken(instrTaken)
    );

    controlUnit decoder0 (.instrWord(instrWord), .ctrl(ctrl));

    // rs and rt fields
    regFile regs0 (
        .clk(clk), .reset(reset),
        .rdAddrA(instrWord[25:21]), .rdAddrB(instrWord[20:16]),
        .rdDataA(rdDataA), .rdDataB(rdDataB),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
    );

    execUnit #(.resetPc(resetPc)) exec0 (
        .clk(clk), .reset(reset), .instrValid(instrValid), .instrWord(instrWord),
        .instrTaken(instrTaken), .ctrl(ctrl), .rdDataA(rdDataA), .rdDataB(rdDataB),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .retire(retire), .retireValid(retireValid), .senderFree(senderFree)
    );

    resultSender sender0 (
        .clk(clk), .reset(reset), .retire(retire), .retireValid(retireValid),
        .senderFree(senderFree), .outReq(outReq), .record(record), .outAck(outAck)
    );

endmodule

/* mipsLite_assertions.sv */
`timescale 1ns/1ns

module mipsLite_assertions #(
    parameter int width        = 32,
    parameter bit producerSide = 1'b1
) (
    input logic             clk,
    input logic             reset,
    input logic             req,
    input logic             ack,
    input logic [width-1:0] data
);

    //////////////////////////////////////////////////
    // Producer side of a link
    //////////////////////////////////////////////////

    reqHeld: assert property (@(posedge clk) disable iff (reset)
        producerSide && req && !ack |=> req)
        else $error("req dropped before ack");

    dataStable: assert property (@(posedge clk) disable iff (reset)
        producerSide && req |=> !req || $stable(data))
        else $error("payload changed while req was high");

    // Consumer side
    ackAfterReq: assert property (@(posedge clk) disable iff (reset)
        !producerSide && $rose(ack) |-> $past(req))
        else $error("ack rose without a pending req");

    ackResetLow: assert property (@(posedge clk)
        !producerSide && reset |=> !ack)
        else $error("ack high right after reset");

endmodule

bind resultSender mipsLite_assertions #(.width(104), .producerSide(1'b1)) senderChecks (
    .clk(clk), .reset(reset), .req(outReq), .ack(outAck), .data(record)
);

bind instrReceiver mipsLite_assertions #(.width(32), .producerSide(1'b0)) receiverChecks (
    .clk(clk), .reset(reset), .req(inReq), .ack(inAck), .data(instr)
);

/* mipsLite_tb.sv */
`timescale 1ns/1ns

module mipsLite_tb import mipsLitePkg::*; ();

    localparam int timeoutCycles = 200;

    logic         clk;
    logic         reset;
    logic         inReq;
    logic [31:0]  instr;
    logic         inAck;
    logic         outReq;
    retireRecordT record;
    logic         outAck;

    logic [31:0]  rowInstr[$];
    retireRecordT rowExp[$];

    mipsLiteTop dut0 (
        .clk(clk), .reset(reset), .inReq(inReq), .instr(instr), .inAck(inAck),
        .outReq(outReq), .record(record), .outAck(outAck)
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////
    // Failure reporting
    //////////////////////////////////////////////////

    task automatic failRun();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic reportMismatch(input int idx, input string field);
        $display("CHECK FAILED at %0t ns: record %0d has a wrong %s", $time, idx, field);
        failRun();
    endtask

    task automatic timedOut(input string what);
        $display("Timeout at %0t ns while waiting for %s", $time, what);
        failRun();
    endtask

    //////////////////////////////////////////////////
    // Handshake waits
    //////////////////////////////////////////////////

    task automatic waitInAck(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (inAck !== level) begin
            @(posedge clk);
            cycles++;
            if (cycles > timeoutCycles) timedOut(what);
        end
    endtask

    task automatic waitOutReq(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (outReq !== level) begin
            @(posedge clk);
            cycles++;
            if (cycles > timeoutCycles) timedOut(what);
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////

    task automatic addRow(input logic [31:0] word, input logic [31:0] pc,
                          input logic [31:0] nextPc,
                          input logic regWrite, input logic [4:0] wrReg,
                          input logic [31:0] wrData, input excCodeT exc);
        retireRecordT row;
        row.pc       = pc;
        row.nextPc   = nextPc;
        row.regWrite = regWrite;
        row.wrReg    = wrReg;
        row.wrData   = wrData;
        row.exc      = exc;
        rowInstr.push_back(word);
        rowExp.push_back(row);
    endtask

    task automatic loadTable();
        // Arithmetic, compare and logic; r1 = 5, r2 = -3
        addRow(32'h2401_0005, 32'h3000, 32'h3004, 1'b1, 5'd1, 32'h0000_0005, excNone);
        addRow(32'h2002_FFFD, 32'h3004, 32'h3008, 1'b1, 5'd2, 32'hFFFF_FFFD, excNone);
        addRow(32'h0041_182A, 32'h3008, 32'h300C, 1'b1, 5'd3, 32'h0000_0001, excNone);
        addRow(32'h0041_202B, 32'h300C, 32'h3010, 1'b1, 5'd4, 32'h0000_0000, excNone);
        addRow(32'h3045_00F0, 32'h3010, 32'h3014, 1'b1, 5'd5, 32'h0000_00F0, excNone);
        addRow(32'h3426_8000, 32'h3014, 32'h3018, 1'b1, 5'd6, 32'h0000_8005, excNone);
        addRow(32'h3C07_7FFF, 32'h3018, 32'h301C, 1'b1, 5'd7, 32'h7FFF_0000, excNone);
        // Overflow cases, then reads showing the targets unchanged
        addRow(32'h00E7_4020, 32'h301C, 32'h3020, 1'b0, 5'd0, 32'h0, excOverflow);
        addRow(32'h0100_4825, 32'h3020, 32'h3024, 1'b1, 5'd9, 32'h0000_0000, excNone);
        addRow(32'h34EB_FFFF, 32'h3024, 32'h3028, 1'b1, 5'd11, 32'h7FFF_FFFF, excNone);
        addRow(32'h216C_0001, 32'h3028, 32'h302C, 1'b0, 5'd0, 32'h0, excOverflow);
        addRow(32'h004B_6822, 32'h302C, 32'h3030, 1'b0, 5'd0, 32'h0, excOverflow);
        addRow(32'h004B_6823, 32'h3030, 32'h3034, 1'b1, 5'd13, 32'h7FFF_FFFE, excNone);
        addRow(32'h0181_7021, 32'h3034, 32'h3038, 1'b1, 5'd14, 32'h0000_0005, excNone);
        addRow(32'h0046_7824, 32'h3038, 32'h303C, 1'b1, 5'd15, 32'h0000_8005, excNone);
        // Register 0 written, then read back
        addRow(32'h2420_0007, 32'h303C, 32'h3040, 1'b1, 5'd0, 32'h0000_000C, excNone);
        addRow(32'h0000_8021, 32'h3040, 32'h3044, 1'b1, 5'd16, 32'h0000_0000, excNone);
        // Reserved encodings and the all-zero no-op
        addRow(32'hFFFF_FFFF, 32'h3044, 32'h3048, 1'b0, 5'd0, 32'h0, excReservedInstr);
        addRow(32'h0001_0840, 32'h3048, 32'h304C, 1'b0, 5'd0, 32'h0, excReservedInstr);
        addRow(32'h0000_0000, 32'h304C, 32'h3050, 1'b1, 5'd0, 32'h0000_0000, excNone);
        addRow(32'h0020_8821, 32'h3050, 32'h3054, 1'b1, 5'd17, 32'h0000_0005, excNone);
        // Branches, jal and jr
        addRow(32'h102E_0003, 32'h3054, 32'h3064, 1'b0, 5'd0, 32'h0, excNone);
        addRow(32'h142E_0003, 32'h3064, 32'h3068, 1'b0, 5'd0, 32'h0, excNone);
        addRow(32'h1022_FFFE, 32'h3068, 32'h306C, 1'b0, 5'd0, 32'h0, excNone);
        addRow(32'h1422_FFFC, 32'h306C, 32'h3060, 1'b0, 5'd0, 32'h0, excNone);
        addRow(32'h0C00_0C40, 32'h3060, 32'h3100, 1'b1, 5'd31, 32'h0000_3068, excNone);
        addRow(32'h03E0_0008, 32'h3100, 32'h3068, 1'b0, 5'd0, 32'h0, excNone);
        // Signed against unsigned compare on a negative operand
        addRow(32'h3C12_8000, 32'h3068, 32'h306C, 1'b1, 5'd18, 32'h8000_0000, excNone);
        addRow(32'h0241_982A, 32'h306C, 32'h3070, 1'b1, 5'd19, 32'h0000_0001, excNone);
        addRow(32'h0241_A02B, 32'h3070, 32'h3074, 1'b1, 5'd20, 32'h0000_0000, excNone);
    endtask

    //////////////////////////////////////////////////
    // Input driver and output responder
    //////////////////////////////////////////////////

    task automatic checkRecord(input int idx);
        retireRecordT expected;
        expected = rowExp[idx];
        assert (record.pc === expected.pc) else reportMismatch(idx, "pc");
        assert (record.nextPc === expected.nextPc) else reportMismatch(idx, "nextPc");
        assert (record.regWrite === expected.regWrite) else reportMismatch(idx, "regWrite");
        assert (record.exc === expected.exc) else reportMismatch(idx, "exc");
        // Destination only matters when a write happens
        if (expected.regWrite) begin
            assert (record.wrReg === expected.wrReg) else reportMismatch(idx, "wrReg");
            assert (record.wrData === expected.wrData) else reportMismatch(idx, "wrData");
        end
    endtask

    task automatic driveInputs();
        for (int i = 0; i < rowInstr.size(); i++) begin
            @(posedge clk);
            instr <= rowInstr[i];
            inReq <= 1'b1;
            waitInAck(1'b1, "inAck to rise");
            inReq <= 1'b0;
            waitInAck(1'b0, "inAck to fall");
        end
    endtask

    task automatic respondOutputs();
        int delay;
        for (int i = 0; i < rowExp.size(); i++) begin
            waitOutReq(1'b1, "outReq to rise");
            delay = $urandom % 5;
            repeat (delay) @(posedge clk);
            checkRecord(i);
            outAck <= 1'b1;
            waitOutReq(1'b0, "outReq to fall");
            outAck <= 1'b0;
        end
    endtask

    initial begin : mainFlow
        clk    = 1'b0;
        reset  = 1'b1;
        inReq  = 1'b0;
        instr  = 32'd0;
        outAck = 1'b0;
        void'($urandom(1));
        loadTable();
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        fork
            driveInputs();
            respondOutputs();
        join
        // Nothing more may come out
        repeat (10) @(posedge clk);
        assert (outReq === 1'b0) else begin
            $display("CHECK FAILED at %0t ns: outReq raised after the last record", $time);
            failRun();
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* mipsLite.f */
mipsLitePkg.sv
instrReceiver.sv
controlUnit.sv
regFile.sv
execUnit.sv
resultSender.sv
mipsLiteTop.sv
mipsLite_assertions.sv
mipsLite_tb.sv
